//--- Makefile
# Verilator build and run of the block transfer testbench.
VERILATOR ?= verilator
TOP       ?= block_xfer_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Checks failed" $(LOG) || ! grep -q "All checks passed" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/block_xfer_tb.sv
// Testbench for the block transfer engine.
// Runs a table of LDI/LDD/LDIR/LDDR cases against a byte memory model.
`timescale 1ns/100ps
`include "z80_block_defs.svh"

module block_xfer_tb;

    localparam int period_ns    = 8;
    localparam int reset_cycles = 5;
    localparam int num_tests    = 5;
    localparam int mem_size     = 65536;

    logic                  clk;
    logic                  reset;
    logic                  start;
    z80_ctrl_pkg::opcode_t opcode;
    logic                  load;
    z80_types_pkg::pair_t  bc_in;
    z80_types_pkg::pair_t  de_in;
    z80_types_pkg::pair_t  hl_in;
    z80_types_pkg::addr_t  mem_addr;
    logic                  mem_rd;
    logic                  mem_wr;
    z80_types_pkg::byte_t  mem_wdata;
    z80_types_pkg::byte_t  mem_rdata;
    logic                  busy;
    logic                  done;
    z80_types_pkg::pair_t  bc;
    z80_types_pkg::pair_t  de;
    z80_types_pkg::pair_t  hl;
    logic                  flag_pv;
    logic                  flag_n;
    logic                  flag_h;

    // stimulus table with a start pulse while busy on poke rows.
    string                 tc_name   [num_tests] = '{"ldi_bc5", "ldd_bc1", "ldir_bc4",
                                                     "ldir_bc1", "lddr_bc3"};
    z80_ctrl_pkg::opcode_t tc_opcode [num_tests] = '{`Z80_OPC_LDI, `Z80_OPC_LDD,
                                                     `Z80_OPC_LDIR, `Z80_OPC_LDIR,
                                                     `Z80_OPC_LDDR};
    z80_types_pkg::pair_t  tc_bc     [num_tests] = '{16'd5, 16'd1, 16'd4, 16'd1, 16'd3};
    z80_types_pkg::pair_t  tc_de     [num_tests] = '{16'h4000, 16'h4100, 16'h4200,
                                                     16'h4300, 16'h4480};
    z80_types_pkg::pair_t  tc_hl     [num_tests] = '{16'h1000, 16'h1100, 16'h1200,
                                                     16'h1300, 16'h1480};
    bit                    tc_poke   [num_tests] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1};

    z80_types_pkg::byte_t mem     [mem_size];
    z80_types_pkg::byte_t exp_mem [mem_size];
    logic [31:0]          lfsr_state;
    int                   errors;
    int                   cycle_count;

    tb_clock_gen #(
        .period_ns    (period_ns),
        .reset_cycles (reset_cycles)
    ) i_clk (
        .clk   (clk),
        .reset (reset)
    );

    block_xfer_top i_dut (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .opcode    (opcode),
        .load      (load),
        .bc_in     (bc_in),
        .de_in     (de_in),
        .hl_in     (hl_in),
        .mem_addr  (mem_addr),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .busy      (busy),
        .done      (done),
        .bc        (bc),
        .de        (de),
        .hl        (hl),
        .flag_pv   (flag_pv),
        .flag_n    (flag_n),
        .flag_h    (flag_h)
    );

    // zero wait memory with bad data outside mem_rd.
    assign mem_rdata = mem_rd ? mem[mem_addr] : ~mem[mem_addr];

    always @(posedge clk) begin
        if (mem_wr) begin
            mem[mem_addr] = mem_wdata;
        end
    end

    // right shift Galois form of x^32 + x^30 + x^26 + x^25 + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'hA300_0000;
        end
        return n;
    endfunction

    function automatic int iter_count(input int idx);
        int n;
        n = 1;
        if (tc_opcode[idx][4]) begin
            n = int'(tc_bc[idx]);  // repeat runs down the whole count.
        end
        return n;
    endfunction

    function automatic int timeout_limit();
        int total;
        int i;
        total = reset_cycles;
        for (i = 0; i < num_tests; i++) begin
            total = total + 8 * iter_count(i) + 20;
        end
        return total;
    endfunction

    task automatic fill_memory();
        z80_types_pkg::byte_t b;
        int                   a;
        int                   k;
        for (a = 0; a < mem_size; a++) begin
            for (k = 0; k < 8; k++) begin
                b[k]       = lfsr_state[0];
                lfsr_state = lfsr_next(lfsr_state);
            end
            mem[a] = b;
        end
    endtask

    task automatic check_equal(input string test, input string what,
                               input logic [31:0] exp_val, input logic [31:0] act_val);
        assert (act_val == exp_val) else begin
            errors++;
            $display("Fail %s %s: expected %0h, actual %0h", test, what, exp_val, act_val);
        end
    endtask

    task automatic check_memory(input string test);
        int a;
        for (a = 0; a < mem_size; a++) begin
            assert (mem[a] == exp_mem[a]) else begin
                errors++;
                $display("Fail %s mem[%04h]: expected %02h, actual %02h",
                         test, a[15:0], exp_mem[a], mem[a]);
            end
        end
    endtask

    // byte by byte move on a snapshot as the CPU does it.
    task automatic model_transfer(input int idx, output z80_types_pkg::pair_t exp_de,
                                  output z80_types_pkg::pair_t exp_hl);
        z80_types_pkg::pair_t d;
        z80_types_pkg::pair_t h;
        int                   a;
        int                   i;
        for (a = 0; a < mem_size; a++) begin
            exp_mem[a] = mem[a];
        end
        d = tc_de[idx];
        h = tc_hl[idx];
        for (i = 0; i < iter_count(idx); i++) begin
            exp_mem[d] = exp_mem[h];
            if (tc_opcode[idx][3]) begin
                d = d - 16'd1;
                h = h - 16'd1;
            end else begin
                d = d + 16'd1;
                h = h + 16'd1;
            end
        end
        exp_de = d;
        exp_hl = h;
    endtask

    task automatic check_reset_state();
        check_equal("reset", "busy", 32'd0, 32'(busy));
        check_equal("reset", "done", 32'd0, 32'(done));
        check_equal("reset", "mem_rd", 32'd0, 32'(mem_rd));
        check_equal("reset", "mem_wr", 32'd0, 32'(mem_wr));
        check_equal("reset", "bc", 32'd0, 32'(bc));
        check_equal("reset", "de", 32'd0, 32'(de));
        check_equal("reset", "hl", 32'd0, 32'(hl));
        check_equal("reset", "flag_pv", 32'd0, 32'(flag_pv));
        check_equal("reset", "flag_n", 32'd0, 32'(flag_n));
        check_equal("reset", "flag_h", 32'd0, 32'(flag_h));
    endtask

    task automatic run_row(input int idx);
        z80_types_pkg::pair_t exp_bc;
        z80_types_pkg::pair_t exp_de;
        z80_types_pkg::pair_t exp_hl;
        int                   n;
        int                   cycles;
        n = iter_count(idx);
        model_transfer(idx, exp_de, exp_hl);
        exp_bc = tc_bc[idx] - 16'(n);
        opcode = tc_opcode[idx];  // held until the next row.
        bc_in  = tc_bc[idx];
        de_in  = tc_de[idx];
        hl_in  = tc_hl[idx];
        load   = 1'b1;
        @(posedge clk);
        #1;
        load   = 1'b0;
        start  = 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
            start = 1'b0;
            if (cycles == 1) begin
                check_equal(tc_name[idx], "busy", 32'd1, 32'(busy));
            end
            if (tc_poke[idx] && cycles == 3) begin
                start = 1'b1;  // must be ignored.
            end
        end while (!done);
        check_equal(tc_name[idx], "done_cycles", 32'(8 * n + 1), 32'(cycles));
        check_equal(tc_name[idx], "bc", 32'(exp_bc), 32'(bc));
        check_equal(tc_name[idx], "de", 32'(exp_de), 32'(de));
        check_equal(tc_name[idx], "hl", 32'(exp_hl), 32'(hl));
        check_equal(tc_name[idx], "flag_pv", 32'(exp_bc != 16'd0), 32'(flag_pv));
        check_equal(tc_name[idx], "flag_n", 32'd0, 32'(flag_n));
        check_equal(tc_name[idx], "flag_h", 32'd0, 32'(flag_h));
        check_equal(tc_name[idx], "busy_after", 32'd0, 32'(busy));
        check_memory(tc_name[idx]);
    endtask

    // watchdog.
    initial begin
        int limit;
        limit       = timeout_limit();
        cycle_count = 0;
        while (cycle_count < limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", limit);
        $display("Checks failed");
        $finish;
    end

    initial begin
        int i;
        start      = 1'b0;
        opcode     = `Z80_OPC_LDI;
        load       = 1'b0;
        bc_in      = '0;
        de_in      = '0;
        hl_in      = '0;
        errors     = 0;
        lfsr_state = 32'd70002;
        fill_memory();
        do begin
            @(posedge clk);
        end while (reset);
        #1;
        check_reset_state();
        for (i = 0; i < num_tests; i++) begin
            run_row(i);
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- dv/tb_clock_gen.sv
// Testbench clock and reset generator.
// Free running clock with a synchronous reset held for a few cycles.
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 reset = 1'b0;  // off the edge, like the other inputs.
    end

endmodule

//--- src.f
+incdir+verilog
verilog/z80_types_pkg.sv
verilog/z80_ctrl_pkg.sv
verilog/ctrl_strobe_if.sv
verilog/xpt_sequencer.sv
verilog/block_xfer_decoder.sv
verilog/block_xfer_datapath.sv
verilog/block_xfer_top.sv
dv/tb_clock_gen.sv
dv/block_xfer_tb.sv

//--- verilog/block_xfer_datapath.sv
// Block transfer datapath.
// BC/DE/HL, data latch, shared step adder, flags and memory strobes.
`timescale 1ns/100ps

module block_xfer_datapath (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load,
    input  z80_types_pkg::pair_t bc_in,
    input  z80_types_pkg::pair_t de_in,
    input  z80_types_pkg::pair_t hl_in,
    ctrl_strobe_if.datapath      strobes,
    output z80_types_pkg::addr_t mem_addr,
    output logic                 mem_rd,
    output logic                 mem_wr,
    output z80_types_pkg::byte_t mem_wdata,
    input  z80_types_pkg::byte_t mem_rdata,
    output z80_types_pkg::pair_t bc,
    output z80_types_pkg::pair_t de,
    output z80_types_pkg::pair_t hl,
    output logic                 bc_zero,
    output logic                 flag_pv,
    output logic                 flag_n,
    output logic                 flag_h
);

    z80_types_pkg::pair_t alu_operand;
    z80_types_pkg::pair_t alu_result;
    z80_types_pkg::byte_t dt;
    logic                 xfer_active;

    // some strobe is high in every state 4 to 11.
    assign xfer_active = strobes.rd_phase | strobes.wr_phase |
                         strobes.bc_write | strobes.hl_write;

    // operand select for the shared adder.
    always_comb begin
        if (strobes.bc_write) begin
            alu_operand = bc;
        end else if (strobes.hl_write) begin
            alu_operand = hl;
        end else begin
            alu_operand = de;
        end
    end

    always_comb begin
        if (strobes.alu_sub) begin
            alu_result = alu_operand - 16'd1;
        end else if (strobes.alu_add) begin
            alu_result = alu_operand + 16'd1;
        end else begin
            alu_result = alu_operand;
        end
    end

    // register pairs and flags.
    always_ff @(posedge clk) begin
        if (reset) begin
            bc      <= '0;
            de      <= '0;
            hl      <= '0;
            flag_pv <= 1'b0;
            flag_n  <= 1'b0;
            flag_h  <= 1'b0;
        end else if (load && !xfer_active) begin
            bc <= bc_in;
            de <= de_in;
            hl <= hl_in;
        end else begin
            if (strobes.de_write) begin
                de <= alu_result;
            end
            if (strobes.bc_write) begin
                bc <= alu_result;
            end
            if (strobes.hl_write) begin
                hl <= alu_result;
            end
            if (strobes.flag_write) begin
                flag_pv <= (alu_result != 16'd0);  // new BC.
                flag_n  <= 1'b0;
                flag_h  <= 1'b0;
            end
        end
    end

    // byte in transit.
    always_ff @(posedge clk) begin
        if (strobes.dt_write) begin
            dt <= mem_rdata;
        end
    end

    // source address on read, destination on write.
    assign mem_addr  = strobes.sel_ad_de ? de : hl;
    assign mem_rd    = strobes.rd_phase;
    assign mem_wr    = strobes.wr_phase;
    assign mem_wdata = dt;

    assign bc_zero = (bc == 16'd0);

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset)
        !(mem_rd && mem_wr));

    // BC = 0 on entry would wrap to FFFF.
    a_bc_nonzero: assert property (@(posedge clk) disable iff (reset)
        strobes.bc_write |-> !bc_zero);

endmodule

//--- verilog/block_xfer_decoder.sv
// LDI/LDD/LDIR/LDDR control decoder.
// Turns the transfer state and opcode into per-state strobes.
`timescale 1ns/100ps

module block_xfer_decoder (
    input  z80_ctrl_pkg::xpt_t    xpt,
    input  logic                  xpt_valid,
    input  z80_ctrl_pkg::opcode_t opcode,
    ctrl_strobe_if.decoder        strobes
);

    logic        t01xx;
    logic        t10xx;
    logic [11:4] dec;
    logic        t4_6;
    logic        t7_9;
    logic        t9or11;
    logic        sub_dir;

    // upper split with bit 4 never set in a transfer.
    assign t01xx = xpt_valid && !xpt[4] && (xpt[3:2] == 2'b01);
    assign t10xx = xpt_valid && !xpt[4] && (xpt[3:2] == 2'b10);

    // lower split inside each group.
    assign dec[4]  = t01xx && (xpt[1:0] == 2'b00);
    assign dec[5]  = t01xx && (xpt[1:0] == 2'b01);
    assign dec[6]  = t01xx && (xpt[1:0] == 2'b10);
    assign dec[7]  = t01xx && (xpt[1:0] == 2'b11);
    assign dec[8]  = t10xx && (xpt[1:0] == 2'b00);
    assign dec[9]  = t10xx && (xpt[1:0] == 2'b01);
    assign dec[10] = t10xx && (xpt[1:0] == 2'b10);
    assign dec[11] = t10xx && (xpt[1:0] == 2'b11);

    // read window.
    assign t4_6 = dec[4] || dec[5] || dec[6];

    // write window.
    assign t7_9 = dec[7] || dec[8] || dec[9];

    assign strobes.rd_phase  = t4_6;
    assign strobes.dt_write  = dec[6];
    assign strobes.sel_ad_de = t7_9;
    assign strobes.wr_phase  = t7_9;

    // pointer and counter updates.
    assign strobes.de_write   = dec[9];
    assign strobes.bc_write   = dec[10];
    assign strobes.flag_write = dec[10];
    assign strobes.hl_write   = dec[11];

    // direction of the DE/HL step while BC always counts down.
    assign t9or11  = dec[9] || dec[11];
    assign sub_dir = opcode[3];

    assign strobes.alu_add = t9or11 && !sub_dir;
    assign strobes.alu_sub = (t9or11 && sub_dir) || dec[10];

endmodule

//--- verilog/block_xfer_top.sv
// Block transfer engine top level.
// Joins sequencer, decoder and datapath behind plain ports.
`timescale 1ns/100ps

module block_xfer_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  z80_ctrl_pkg::opcode_t opcode,
    input  logic                  load,
    input  z80_types_pkg::pair_t  bc_in,
    input  z80_types_pkg::pair_t  de_in,
    input  z80_types_pkg::pair_t  hl_in,
    output z80_types_pkg::addr_t  mem_addr,
    output logic                  mem_rd,
    output logic                  mem_wr,
    output z80_types_pkg::byte_t  mem_wdata,
    input  z80_types_pkg::byte_t  mem_rdata,
    output logic                  busy,
    output logic                  done,
    output z80_types_pkg::pair_t  bc,
    output z80_types_pkg::pair_t  de,
    output z80_types_pkg::pair_t  hl,
    output logic                  flag_pv,
    output logic                  flag_n,
    output logic                  flag_h
);

    z80_ctrl_pkg::xpt_t xpt;
    logic               xpt_valid;
    logic               bc_zero;

    ctrl_strobe_if strobes ();

    xpt_sequencer i_seq (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .opcode    (opcode),
        .bc_zero   (bc_zero),
        .xpt       (xpt),
        .xpt_valid (xpt_valid),
        .busy      (busy),
        .done      (done)
    );

    // opcode must stay stable while busy.
    block_xfer_decoder i_dec (
        .xpt       (xpt),
        .xpt_valid (xpt_valid),
        .opcode    (opcode),
        .strobes   (strobes.decoder)
    );

    block_xfer_datapath i_dp (
        .clk       (clk),
        .reset     (reset),
        .load      (load),
        .bc_in     (bc_in),
        .de_in     (de_in),
        .hl_in     (hl_in),
        .strobes   (strobes.datapath),
        .mem_addr  (mem_addr),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .bc        (bc),
        .de        (de),
        .hl        (hl),
        .bc_zero   (bc_zero),
        .flag_pv   (flag_pv),
        .flag_n    (flag_n),
        .flag_h    (flag_h)
    );

endmodule

//--- verilog/ctrl_strobe_if.sv
// Decoded control strobes of one block transfer iteration.
// Driven by the decoder and consumed by the datapath.
`timescale 1ns/100ps

interface ctrl_strobe_if;

    logic rd_phase;   // read on HL.
    logic dt_write;   // latch read byte.
    logic sel_ad_de;  // address from DE.
    logic wr_phase;   // write enable.
    logic de_write;
    logic bc_write;
    logic flag_write;
    logic hl_write;
    logic alu_add;
    logic alu_sub;

    modport decoder (
        output rd_phase,
        output dt_write,
        output sel_ad_de,
        output wr_phase,
        output de_write,
        output bc_write,
        output flag_write,
        output hl_write,
        output alu_add,
        output alu_sub
    );

    modport datapath (
        input rd_phase,
        input dt_write,
        input sel_ad_de,
        input wr_phase,
        input de_write,
        input bc_write,
        input flag_write,
        input hl_write,
        input alu_add,
        input alu_sub
    );

endinterface

//--- verilog/xpt_sequencer.sv
// Transfer state sequencer.
// Steps XPT from 4 to 11 per iteration, then repeats or signals done.
`timescale 1ns/100ps
`include "z80_block_defs.svh"

module xpt_sequencer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  z80_ctrl_pkg::opcode_t opcode,
    input  logic                  bc_zero,
    output z80_ctrl_pkg::xpt_t    xpt,
    output logic                  xpt_valid,
    output logic                  busy,
    output logic                  done
);

    z80_ctrl_pkg::seq_state_e state;
    z80_ctrl_pkg::opcode_t    opcode_q;
    logic                     last_xpt;
    logic                     repeat_xfer;

    assign last_xpt    = (xpt == `Z80_XPT_LAST);
    assign repeat_xfer = opcode_q[4] && !bc_zero;  // LDIR/LDDR with count left.

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= z80_ctrl_pkg::SEQ_IDLE;
            xpt   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                z80_ctrl_pkg::SEQ_IDLE: begin
                    if (start) begin
                        state <= z80_ctrl_pkg::SEQ_RUN;
                        xpt   <= `Z80_XPT_FIRST;
                    end
                end
                z80_ctrl_pkg::SEQ_RUN: begin
                    if (!last_xpt) begin
                        xpt <= xpt + 5'd1;
                    end else if (repeat_xfer) begin
                        xpt <= `Z80_XPT_FIRST;  // next iteration.
                    end else begin
                        state <= z80_ctrl_pkg::SEQ_IDLE;
                        xpt   <= '0;
                        done  <= 1'b1;
                    end
                end
                default: state <= z80_ctrl_pkg::SEQ_IDLE;
            endcase
        end
    end

    // only the repeat bit matters here.
    always_ff @(posedge clk) begin
        if (state == z80_ctrl_pkg::SEQ_IDLE && start) begin
            opcode_q <= opcode;
        end
    end

    assign xpt_valid = (state == z80_ctrl_pkg::SEQ_RUN);
    assign busy      = (state == z80_ctrl_pkg::SEQ_RUN);

    a_xpt_range: assert property (@(posedge clk) disable iff (reset)
        xpt_valid |-> (xpt >= `Z80_XPT_FIRST && xpt <= `Z80_XPT_LAST));

    a_start_opcode: assert property (@(posedge clk) disable iff (reset)
        (start && !busy) |-> (opcode inside {`Z80_OPC_LDI, `Z80_OPC_LDD,
                                              `Z80_OPC_LDIR, `Z80_OPC_LDDR}));

endmodule

//--- verilog/z80_block_defs.svh
// Z80 block transfer constants.
// Covers the transfer state range, address width and the LDxx opcodes.
`ifndef Z80_BLOCK_DEFS_SVH
`define Z80_BLOCK_DEFS_SVH

// transfer state range, opcode fetch ends at 3.
`define Z80_XPT_FIRST 5'd4
`define Z80_XPT_LAST  5'd11

`define Z80_ADDR_W 16

// second byte after the ED prefix.
`define Z80_OPC_LDI  8'hA0
`define Z80_OPC_LDD  8'hA8
`define Z80_OPC_LDIR 8'hB0
`define Z80_OPC_LDDR 8'hB8

`endif

//--- verilog/z80_ctrl_pkg.sv
// Z80 control types.
// Transfer state number, opcode byte and sequencer state.
package z80_ctrl_pkg;

    // transfer state, 4 to 11 during a block move.
    typedef logic [4:0] xpt_t;

    // bit 3 decrement, bit 4 repeat.
    typedef logic [7:0] opcode_t;

    typedef enum logic {
        SEQ_IDLE = 1'b0,
        SEQ_RUN  = 1'b1
    } seq_state_e;

endpackage

//--- verilog/z80_types_pkg.sv
// Z80 data types.
// Byte, address and register pair vectors of the block transfer engine.
`include "z80_block_defs.svh"

package z80_types_pkg;

    // one data byte on the memory bus.
    typedef logic [7:0] byte_t;

    // memory address.
    typedef logic [`Z80_ADDR_W-1:0] addr_t;

    // BC, DE and HL.
    typedef logic [15:0] pair_t;

endpackage
